//--- video_top.f
+incdir+verilog
verilog/video_pkg.sv
verilog/write_fifo.sv
verilog/video_bus.sv
verilog/vram.sv
verilog/scan_timer.sv
verilog/video_top.sv
tb/video_checker.sv
tb/tb_video_top.sv

//--- Makefile
SIM := obj_dir/Vtb_video_top
SRCS := $(wildcard verilog/*.sv verilog/*.svh tb/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): video_top.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f video_top.f --top-module tb_video_top \
		-o Vtb_video_top

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

//--- tb/video_stim.txt
# Columns: command letter, then up to two hex arguments
# W addr data | R count step | P first count | V | A | C | T test_id expect_fifo_full
T 5 0
V
W 01000000 00112233
W 010003fc 00aabbcc
W 00000000 ff00ff00
W 00012bfc 00ff00ff
C
T 1 0
V
P 1 10
W 00000000 04030201
W 0000013c 08070605
W 00012ac0 0c0b0a09
W 00012bfc 100f0e0d
C
T 2 0
V
R 96 3
P 0 100
C
T 3 0
A
R 12c 7
V
C
T 4 1

//--- tb/tb_video_top.sv
`include "video_defs.svh"

module tb_video_top import video_pkg::*; ();

	logic i_clock = 1'b0;
	logic i_rst;
	logic cpu_request;
	logic [31:0] cpu_address;
	logic [31:0] cpu_wdata;
	logic cpu_ready;
	logic pixel_valid;
	pos_t pixel_x;
	pos_t pixel_y;
	rgb_t pixel_rgb;
	logic vblank;
	logic fifo_full;
	logic check_req;
	logic check_done;
	logic test_end;
	logic [7:0] test_id;
	logic expect_full;
	logic finish_req;
	logic [31:0] errors;
	logic stim_loaded;
	longint watch_limit;
	logic [31:0] rng;
	string cmds[$];
	logic [31:0] arg_a[$];
	logic [31:0] arg_b[$];

	video_top u_dut (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_cpu_request(cpu_request),
		.i_cpu_address(cpu_address),
		.i_cpu_wdata(cpu_wdata),
		.o_cpu_ready(cpu_ready),
		.o_pixel_valid(pixel_valid),
		.o_pixel_x(pixel_x),
		.o_pixel_y(pixel_y),
		.o_pixel_rgb(pixel_rgb),
		.o_vblank(vblank),
		.o_fifo_full(fifo_full)
	);

	video_checker u_checker (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_cpu_request(cpu_request),
		.i_cpu_address(cpu_address),
		.i_cpu_wdata(cpu_wdata),
		.i_cpu_ready(cpu_ready),
		.i_pixel_valid(pixel_valid),
		.i_pixel_x(pixel_x),
		.i_pixel_y(pixel_y),
		.i_pixel_rgb(pixel_rgb),
		.i_fifo_full(fifo_full),
		.i_vblank(vblank),
		.i_check(check_req),
		.o_check_done(check_done),
		.i_test_end(test_end),
		.i_test_id(test_id),
		.i_expect_full(expect_full),
		.i_finish(finish_req),
		.o_errors(errors)
	);

	initial begin
		i_clock = 1'b0;
		forever #20 i_clock = ~i_clock;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic load_stim(output bit ok);
		int fd;
		int n;
		int frames;
		string line;
		string cmd;
		logic [31:0] a;
		logic [31:0] b;
		ok = 1'b1;
		frames = 0;
		fd = $fopen("tb/video_stim.txt", "r");
		if (fd == 0) begin
			$display("Cannot open stimulus file tb/video_stim.txt");
			ok = 1'b0;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				a = '0;
				b = '0;
				if ($fgets(line, fd) > 0) begin
					n = $sscanf(line, "%s %h %h", cmd, a, b);
					if (n >= 1 && cmd != "#") begin
						if (cmd == "W" || cmd == "R" || cmd == "P" || cmd == "V" ||
							cmd == "A" || cmd == "C" || cmd == "T") begin
							cmds.push_back(cmd);
							arg_a.push_back(a);
							arg_b.push_back(b);
							if (cmd == "C")
								frames++;
						end else begin
							$display("Unknown stimulus command %s", cmd);
							ok = 1'b0;
						end
					end
				end
			end
			$fclose(fd);
		end
		// Each checked frame may need nearly two frames of waiting
		watch_limit = longint'(frames + 2) * `H_TOTAL * `V_TOTAL * 40;
	endtask

	task automatic write_word(input logic [31:0] a, input logic [31:0] d);
		cpu_request = 1'b1;
		cpu_address = a;
		cpu_wdata = d;
		do begin
			@(posedge i_clock);
			#2;
		end while (!cpu_ready);
		cpu_request = 1'b0;
	endtask

	task automatic random_burst(input int count, input int step);
		logic [31:0] a;
		repeat (step) rng = xorshift32(rng);
		repeat (count) begin
			rng = xorshift32(rng);
			a = (rng % `VRAM_WORDS) * 4;
			rng = xorshift32(rng);
			write_word(a, rng);
		end
	endtask

	task automatic palette_fill(input int first, input int count);
		for (int k = 0; k < count; k++) begin
			rng = xorshift32(rng);
			write_word(`PALETTE_BASE + (first + k) * 4, rng);
		end
	endtask

	task automatic wait_vblank();
		while (!vblank) begin
			@(posedge i_clock);
			#2;
		end
	endtask

	// Start of the next frame's picture
	task automatic wait_active();
		wait_vblank();
		while (!pixel_valid) begin
			@(posedge i_clock);
			#2;
		end
	endtask

	task automatic check_frame();
		check_req = 1'b1;
		wait (check_done);
		@(posedge i_clock);
		#2;
		check_req = 1'b0;
		wait (!check_done);
	endtask

	task automatic end_test(input logic [31:0] id, input logic [31:0] flag);
		test_id = id[7:0];
		expect_full = flag[0];
		test_end = 1'b1;
		@(posedge i_clock);
		#2;
		test_end = 1'b0;
	endtask

	initial begin : watchdog
		wait (stim_loaded);
		#(watch_limit);
		$display("Watchdog expired after %0d time units with tests still running", watch_limit);
		$display("Simulation failed");
		$finish;
	end

	initial begin : main
		bit ok;
		i_rst = 1'b1;
		cpu_request = 1'b0;
		cpu_address = '0;
		cpu_wdata = '0;
		check_req = 1'b0;
		test_end = 1'b0;
		test_id = '0;
		expect_full = 1'b0;
		finish_req = 1'b0;
		stim_loaded = 1'b0;
		rng = 32'h6a6e;
		load_stim(ok);
		if (!ok) begin
			$display("Stimulus file could not be used");
			$display("Simulation failed");
			$finish;
		end else begin
			stim_loaded = 1'b1;
			repeat (5) @(posedge i_clock);
			#2;
			i_rst = 1'b0;
			foreach (cmds[i]) begin
				case (cmds[i])
					"W": write_word(arg_a[i], arg_b[i]);
					"R": random_burst(arg_a[i], arg_b[i]);
					"P": palette_fill(arg_a[i], arg_b[i]);
					"V": wait_vblank();
					"A": wait_active();
					"C": check_frame();
					default: end_test(arg_a[i], arg_b[i]);
				endcase
			end
			finish_req = 1'b1;
			@(posedge i_clock);
			#2;
			if (errors == 0)
				$display("Simulation completed successfully");
			else
				$display("Simulation failed");
			$finish;
		end
	end

endmodule

//--- tb/video_checker.sv
`include "video_defs.svh"

module video_checker import video_pkg::*; (
	input  logic        i_clock,
	input  logic        i_rst,
	input  logic        i_cpu_request,
	input  logic [31:0] i_cpu_address,
	input  logic [31:0] i_cpu_wdata,
	input  logic        i_cpu_ready,
	input  logic        i_pixel_valid,
	input  pos_t        i_pixel_x,
	input  pos_t        i_pixel_y,
	input  rgb_t        i_pixel_rgb,
	input  logic        i_fifo_full,
	input  logic        i_vblank,
	input  logic        i_check,
	output logic        o_check_done,
	input  logic        i_test_end,
	input  logic [7:0]  i_test_id,
	input  logic        i_expect_full,
	input  logic        i_finish,
	output logic [31:0] o_errors
);

	rgb_t shadow_palette [0:255];
	logic palette_known [0:255];
	logic [31:0] shadow_vram [0:`VRAM_WORDS-1];
	logic vram_known [0:`VRAM_WORDS-1];
	int total_errors;
	int test_errors;
	int tests_run;
	int tests_failed;
	int pixels_checked;
	int waited;
	logic full_seen;
	logic prev_full;
	logic [31:0] req_address;
	logic [31:0] req_wdata;
	int scan_x;
	int scan_y;
	bit scan_known;

	assign o_errors = total_errors;

	task automatic note_error();
		total_errors++;
		test_errors++;
	endtask

	task automatic expect_low(input string name, input logic value);
		if (value !== 1'b0) begin
			$display("ERR %0t %s expected 0 actual %b", $time, name, value);
			note_error();
		end
	endtask

	task automatic finish_test();
		tests_run++;
		if (full_seen != i_expect_full) begin
			$display("Test %0d: write FIFO full flag was %0s seen, contrary to expectation",
				i_test_id, full_seen ? "" : "never");
			note_error();
		end
		if (test_errors == 0) begin
			$display("Test %0d passed", i_test_id);
		end else begin
			$display("Test %0d failed with %0d errors", i_test_id, test_errors);
			tests_failed++;
		end
		test_errors = 0;
		full_seen = 1'b0;
	endtask

	initial begin
		for (int i = 0; i < 256; i++)
			palette_known[i] = 1'b0;
		for (int i = 0; i < `VRAM_WORDS; i++)
			vram_known[i] = 1'b0;
		total_errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		pixels_checked = 0;
		waited = 0;
		full_seen = 1'b0;
		prev_full = 1'b0;
		req_address = '0;
		req_wdata = '0;
	end

	// Bus acceptance, latency, back-pressure, scan timing and reset state
	always @(negedge i_clock) begin : watch_bus
		logic [31:0] offset;
		int word;
		if (i_rst) begin
			expect_low("o_cpu_ready", i_cpu_ready);
			expect_low("o_pixel_valid", i_pixel_valid);
			expect_low("o_fifo_full", i_fifo_full);
			waited = 0;
			prev_full = 1'b0;
			scan_x = 0;
			scan_y = 0;
			scan_known = 1'b1;
		end else begin
			// Frame position counted from reset
			if (scan_known) begin
				if (i_vblank !== (scan_y >= `V_ACTIVE)) begin
					$display("ERR %0t o_vblank expected %0b actual %b",
						$time, scan_y >= `V_ACTIVE, i_vblank);
					note_error();
				end
				if (scan_x == `H_TOTAL - 1) begin
					scan_x = 0;
					scan_y = (scan_y == `V_TOTAL - 1) ? 0 : scan_y + 1;
				end else begin
					scan_x++;
				end
			end
			if (i_cpu_ready) begin
				if (req_address >= `PALETTE_BASE) begin
					if (waited != 1) begin
						$display("Palette write at %0t took %0d cycles to be acknowledged",
							$time, waited);
						note_error();
					end
					offset = req_address - `PALETTE_BASE;
					shadow_palette[offset[9:2]] = req_wdata;
					palette_known[offset[9:2]] = 1'b1;
				end else begin
					if (prev_full) begin
						$display("ERR %0t o_cpu_ready expected 0 actual 1", $time);
						note_error();
					end
					word = req_address >> 2;
					if (word < `VRAM_WORDS) begin
						shadow_vram[word] = req_wdata;
						vram_known[word] = 1'b1;
					end
				end
				waited = 0;
			end else if (i_cpu_request) begin
				// Request as held by the master until its acknowledge
				req_address = i_cpu_address;
				req_wdata = i_cpu_wdata;
				waited++;
			end
			if (i_fifo_full)
				full_seen = 1'b1;
			prev_full = i_fifo_full;
			if (i_test_end)
				finish_test();
			if (i_finish)
				$display("Summary: %0d tests, %0d failed, %0d errors, %0d pixels compared",
					tests_run, tests_failed, total_errors, pixels_checked);
		end
	end

	// One checked frame per request from pixel (0,0) to the last visible pixel
	initial begin : frame_check
		int n;
		int ex;
		int ey;
		int word;
		logic [7:0] index;
		bit cut_short;
		o_check_done = 1'b0;
		forever begin
			wait (i_check);
			@(negedge i_clock);
			while (!(i_pixel_valid && i_pixel_x == 0 && i_pixel_y == 0))
				@(negedge i_clock);
			n = 0;
			ex = 0;
			ey = 0;
			cut_short = 1'b0;
			while (n < `H_ACTIVE * `V_ACTIVE && !cut_short) begin
				if (i_pixel_valid) begin
					if (i_pixel_x != ex || i_pixel_y != ey) begin
						$display("ERR %0t o_pixel_x/o_pixel_y expected %0d,%0d actual %0d,%0d",
							$time, ex, ey, i_pixel_x, i_pixel_y);
						note_error();
						ex = i_pixel_x;
						ey = i_pixel_y;
					end
					word = (ey * `H_ACTIVE + ex) / 4;
					if (word < `VRAM_WORDS && vram_known[word]) begin
						index = shadow_vram[word][(ex % 4) * 8 +: 8];
						if (palette_known[index]) begin
							pixels_checked++;
							if (i_pixel_rgb !== shadow_palette[index]) begin
								$display("ERR %0t o_pixel_rgb at %0d,%0d expected %h actual %h",
									$time, ex, ey, shadow_palette[index], i_pixel_rgb);
								note_error();
							end
						end
					end
					n++;
					ex++;
					if (ex == `H_ACTIVE) begin
						ex = 0;
						ey++;
					end
				end else if (i_pixel_y >= `V_ACTIVE) begin
					cut_short = 1'b1;
				end
				if (n < `H_ACTIVE * `V_ACTIVE && !cut_short)
					@(negedge i_clock);
			end
			if (n != `H_ACTIVE * `V_ACTIVE) begin
				$display("Checked frame ended after only %0d valid pixels", n);
				note_error();
			end
			o_check_done = 1'b1;
			wait (!i_check);
			o_check_done = 1'b0;
		end
	end

endmodule

//--- verilog/video_top.sv
module video_top import video_pkg::*; (
	input  logic        i_clock,
	input  logic        i_rst,
	input  logic        i_cpu_request,
	input  logic [31:0] i_cpu_address,
	input  logic [31:0] i_cpu_wdata,
	output logic        o_cpu_ready,
	output logic        o_pixel_valid,
	output pos_t        o_pixel_x,
	output pos_t        o_pixel_y,
	output rgb_t        o_pixel_rgb,
	output logic        o_vblank,
	output logic        o_fifo_full
);

	pos_t scan_x;
	pos_t scan_y;
	logic scan_active;
	logic scan_prefetch;
	logic mem_request;
	logic mem_rw;
	logic [31:0] mem_address;
	logic [31:0] mem_wdata;
	logic [31:0] mem_rdata;
	logic mem_ready;

	scan_timer u_scan_timer (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.o_pos_x(scan_x),
		.o_pos_y(scan_y),
		.o_active(scan_active),
		.o_prefetch(scan_prefetch),
		.o_vblank(o_vblank)
	);

	video_bus u_video_bus (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_cpu_request(i_cpu_request),
		.i_cpu_address(i_cpu_address),
		.i_cpu_wdata(i_cpu_wdata),
		.o_cpu_ready(o_cpu_ready),
		.i_pos_x(scan_x),
		.i_pos_y(scan_y),
		.i_active(scan_active),
		.i_prefetch(scan_prefetch),
		.o_mem_request(mem_request),
		.o_mem_rw(mem_rw),
		.o_mem_address(mem_address),
		.o_mem_wdata(mem_wdata),
		.i_mem_rdata(mem_rdata),
		.i_mem_ready(mem_ready),
		.o_pixel_valid(o_pixel_valid),
		.o_pixel_x(o_pixel_x),
		.o_pixel_y(o_pixel_y),
		.o_pixel_rgb(o_pixel_rgb),
		.o_fifo_full(o_fifo_full)
	);

	vram u_vram (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_request(mem_request),
		.i_rw(mem_rw),
		.i_address(mem_address),
		.i_wdata(mem_wdata),
		.o_rdata(mem_rdata),
		.o_ready(mem_ready)
	);

endmodule

//--- verilog/scan_timer.sv
`include "video_defs.svh"

module scan_timer import video_pkg::*; (
	input  logic i_clock,
	input  logic i_rst,
	output pos_t o_pos_x,
	output pos_t o_pos_y,
	output logic o_active,
	output logic o_prefetch,
	output logic o_vblank
);

	pos_t pos_x;
	pos_t pos_y;
	logic line_tail;
	logic next_line_active;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			pos_x <= '0;
			pos_y <= '0;
		end else if (pos_x == `H_TOTAL - 1) begin
			pos_x <= '0;
			pos_y <= (pos_y == `V_TOTAL - 1) ? '0 : pos_y + 1'b1;
		end else begin
			pos_x <= pos_x + 1'b1;
		end
	end

	assign o_pos_x = pos_x;
	assign o_pos_y = pos_y;

	assign o_active = (pos_x < `H_ACTIVE) && (pos_y < `V_ACTIVE);
	assign o_vblank = (pos_y >= `V_ACTIVE);

	// Last two clocks of a line lead into the next one
	assign line_tail = (pos_x >= `H_TOTAL - 2);
	assign next_line_active = (pos_y < `V_ACTIVE - 1) || (pos_y == `V_TOTAL - 1);

	// Runs two clocks ahead of the active window
	assign o_prefetch = ((pos_y < `V_ACTIVE) && (pos_x < `H_ACTIVE - 2)) ||
		(line_tail && next_line_active);

endmodule

//--- verilog/vram.sv
`include "video_defs.svh"

module vram (
	input  logic        i_clock,
	input  logic        i_rst,
	input  logic        i_request,
	input  logic        i_rw,
	input  logic [31:0] i_address,
	input  logic [31:0] i_wdata,
	output logic [31:0] o_rdata,
	output logic        o_ready
);

	localparam int INDEX_BITS = $clog2(`VRAM_WORDS);

	logic [31:0] mem [0:`VRAM_WORDS-1];
	logic [29:0] word_index;
	logic in_range;
	logic serve;

	assign word_index = i_address[31:2];
	assign in_range = (word_index < `VRAM_WORDS);
	// Skip the cycle after an answer so a held request is served once
	assign serve = i_request && !o_ready;

	always_ff @(posedge i_clock) begin
		if (i_rst)
			o_ready <= 1'b0;
		else
			o_ready <= serve;
	end

	always_ff @(posedge i_clock) begin
		if (serve) begin
			if (i_rw && in_range)
				mem[word_index[INDEX_BITS-1:0]] <= i_wdata;
			o_rdata <= in_range ? mem[word_index[INDEX_BITS-1:0]] : 32'h0;
		end
	end

endmodule

//--- verilog/video_bus.sv
`include "video_defs.svh"

module video_bus import video_pkg::*; (
	input  logic        i_clock,
	input  logic        i_rst,
	input  logic        i_cpu_request,
	input  logic [31:0] i_cpu_address,
	input  logic [31:0] i_cpu_wdata,
	output logic        o_cpu_ready,
	input  pos_t        i_pos_x,
	input  pos_t        i_pos_y,
	input  logic        i_active,
	input  logic        i_prefetch,
	output logic        o_mem_request,
	output logic        o_mem_rw,
	output logic [31:0] o_mem_address,
	output logic [31:0] o_mem_wdata,
	input  logic [31:0] i_mem_rdata,
	input  logic        i_mem_ready,
	output logic        o_pixel_valid,
	output pos_t        o_pixel_x,
	output pos_t        o_pixel_y,
	output rgb_t        o_pixel_rgb,
	output logic        o_fifo_full
);

	typedef enum logic [1:0] {S_IDLE, S_DRAIN, S_FETCH, S_HOLD} state_t;

	state_t state;
	logic cpu_take;
	logic to_palette;
	logic fifo_write;
	logic fifo_read;
	logic fifo_empty;
	logic fifo_full;
	vram_write_t fifo_wdata;
	vram_write_t fifo_rdata;
	vram_write_t drain_entry;
	rgb_t palette [0:255];
	logic [31:0] palette_offset;
	logic [7:0] palette_index;
	logic fetch_now;
	logic drain_now;
	pos_t fetch_x;
	pos_t fetch_y;
	logic [31:0] fetch_address;
	logic [31:0] fetch_address_q;
	logic [31:0] cur_word;
	logic [31:0] next_word;
	logic [31:0] shown_word;
	logic [7:0] pixel_index;

	write_fifo u_fifo (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_write(fifo_write),
		.i_wdata(fifo_wdata),
		.i_read(fifo_read),
		.o_rdata(fifo_rdata),
		.o_empty(fifo_empty),
		.o_full(fifo_full)
	);

	assign o_fifo_full = fifo_full;

	// CPU writes, one every other cycle at most
	assign cpu_take = i_cpu_request && !o_cpu_ready;
	assign to_palette = (i_cpu_address >= `PALETTE_BASE);
	assign fifo_write = cpu_take && !to_palette && !fifo_full;
	assign fifo_wdata = '{address: i_cpu_address, data: i_cpu_wdata};
	assign palette_offset = i_cpu_address - `PALETTE_BASE;
	assign palette_index = palette_offset[9:2];

	always_ff @(posedge i_clock) begin
		if (i_rst)
			o_cpu_ready <= 1'b0;
		else
			o_cpu_ready <= fifo_write || (cpu_take && to_palette);
	end

	always_ff @(posedge i_clock) begin
		if (cpu_take && to_palette)
			palette[palette_index] <= i_cpu_wdata;
	end

	// Fetch on the third pixel of each group while prefetching
	assign fetch_now = i_prefetch && (i_pos_x[1:0] == 2'd2);
	// Leave room so a drain never overlaps the first fetch of a line
	assign drain_now = !i_prefetch && !fifo_empty && (i_pos_x < `H_TOTAL - 4);
	assign fifo_read = (state == S_IDLE) && drain_now;

	// Group ahead, wrapping into the next line at the end of the line
	always_comb begin
		if (i_pos_x >= `H_ACTIVE) begin
			fetch_x = '0;
			fetch_y = (i_pos_y == `V_TOTAL - 1) ? '0 : i_pos_y + 1'b1;
		end else begin
			fetch_x = i_pos_x + 9'd2;
			fetch_y = i_pos_y;
		end
	end

	assign fetch_address = fetch_y * `H_ACTIVE + fetch_x;

	always_comb begin
		o_mem_request = 1'b0;
		o_mem_rw = 1'b0;
		o_mem_address = fetch_address_q;
		o_mem_wdata = drain_entry.data;
		case (state)
			S_IDLE: begin
				if (fetch_now) begin
					o_mem_request = 1'b1;
					o_mem_address = fetch_address;
				end
			end
			S_DRAIN: begin
				o_mem_request = 1'b1;
				o_mem_rw = 1'b1;
				o_mem_address = drain_entry.address;
			end
			S_FETCH: o_mem_request = 1'b1;
			S_HOLD: o_mem_request = 1'b0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (fetch_now)
						state <= S_FETCH;
					else if (drain_now)
						state <= S_DRAIN;
				end
				S_DRAIN: if (i_mem_ready) state <= S_IDLE;
				S_FETCH: if (i_mem_ready) state <= S_HOLD;
				S_HOLD: if (i_pos_x[1:0] == 2'd0) state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == S_IDLE && fetch_now)
			fetch_address_q <= fetch_address;
		if (fifo_read)
			drain_entry <= fifo_rdata;
		if (state == S_FETCH && i_mem_ready)
			next_word <= i_mem_rdata;
		if (i_pos_x[1:0] == 2'd0)
			cur_word <= next_word;
	end

	// First pixel of a group reads the freshly fetched word
	assign shown_word = (i_pos_x[1:0] == 2'd0) ? next_word : cur_word;
	assign pixel_index = shown_word[i_pos_x[1:0] * 8 +: 8];

	always_ff @(posedge i_clock) begin
		if (i_rst)
			o_pixel_valid <= 1'b0;
		else
			o_pixel_valid <= i_active;
		o_pixel_x <= i_pos_x;
		o_pixel_y <= i_pos_y;
		o_pixel_rgb <= palette[pixel_index];
	end

endmodule

//--- verilog/write_fifo.sv
`include "video_defs.svh"

module write_fifo import video_pkg::*; (
	input  logic        i_clock,
	input  logic        i_rst,
	input  logic        i_write,
	input  vram_write_t i_wdata,
	input  logic        i_read,
	output vram_write_t o_rdata,
	output logic        o_empty,
	output logic        o_full
);

	localparam int PTR_BITS = $clog2(`FIFO_DEPTH);

	vram_write_t entries [0:`FIFO_DEPTH-1];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0] count;
	logic do_write;
	logic do_read;

	assign o_empty = (count == '0);
	assign o_full = (count == `FIFO_DEPTH);
	assign do_write = i_write && !o_full;
	assign do_read = i_read && !o_empty;

	// Head is visible without a read
	assign o_rdata = entries[rd_ptr];

	always_ff @(posedge i_clock) begin
		if (do_write)
			entries[wr_ptr] <= i_wdata;
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_write)
				wr_ptr <= (wr_ptr == `FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= (rd_ptr == `FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			// Simultaneous push and pop cancel out
			if (do_write && !do_read)
				count <= count + 1'b1;
			else if (do_read && !do_write)
				count <= count - 1'b1;
		end
	end

endmodule

//--- verilog/video_pkg.sv
package video_pkg;

	// One queued CPU write to video RAM
	typedef struct packed {
		logic [31:0] address;
		logic [31:0] data;
	} vram_write_t;

	// Screen coordinate, wide enough for the full frame
	typedef logic [8:0] pos_t;

	// Palette colour as stored and shown
	typedef logic [31:0] rgb_t;

endpackage

//--- verilog/video_defs.svh
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// Visible picture
`define H_ACTIVE 320
`define V_ACTIVE 240

// Whole frame including blanking
`define H_TOTAL 400
`define V_TOTAL 262

// Queued VRAM writes
`define FIFO_DEPTH 256

// Palette entry n sits at this base plus 4*n
`define PALETTE_BASE 32'h0100_0000

// Four pixels per word
`define VRAM_WORDS 19200

`endif
